//--- src.f
+incdir+include
design/fp_types_pkg.sv
design/fp_stage_pkg.sv
design/fp_unpack.sv
design/fp_align.sv
design/fp_mant_add.sv
design/fp_normalize.sv
design/fp_round.sv
design/fp_adder.sv
tb/fp_adder_asserts.sv
tb/fp_adder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the fp_adder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module fp_adder_tb \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vfp_adder_tb > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "sim passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }

//--- tb/fp_adder_tb.sv
`timescale 1ns/1ns

module fp_adder_tb import fp_types_pkg::*; ();

  localparam int NUM_OPS      = 3000;
  localparam int NUM_DIRECTED = 10;
  localparam int MAX_GAP      = 3;
  localparam int RESET_CYCLES = 3;
  localparam int PIPE_DEPTH   = 2;
  localparam int TIMEOUT      = RESET_CYCLES + NUM_DIRECTED + NUM_OPS * (1 + MAX_GAP) +
                                PIPE_DEPTH + 20;

  typedef struct packed {
    fp32_t       a;
    fp32_t       b;
    logic [2:0]  mode;
    fp32_t       result;
    logic        ovf;
    logic        unf;
    logic [31:0] issue;
  } expect_t;

  logic        clk = 1'b0;
  logic        reset;
  logic        in_valid;
  fp32_t       op_a;
  fp32_t       op_b;
  round_mode_t r_mode;
  logic        out_valid;
  fp32_t       result;
  logic        overflow;
  logic        underflow;

  integer  seed;
  int      cycles = 0;
  int      result_errors = 0;
  int      flag_errors = 0;
  int      sequence_errors = 0;
  int      gap;
  fp32_t   rand_a;
  fp32_t   rand_b;
  expect_t expected_q[$];

  fp_adder fp_adder_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .r_mode    (r_mode),
    .out_valid (out_valid),
    .result    (result),
    .overflow  (overflow),
    .underflow (underflow)
  );

  bind fp_adder fp_adder_asserts asserts_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .overflow  (overflow),
    .underflow (underflow)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, %0d results never arrived", cycles, expected_q.size());
      $display("sim failed");
      $finish;
    end
  end

  function automatic int urand(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Infinity, NaN, signed zero or an arbitrary word
  function automatic fp32_t pick_special();
    fp32_t x;
    x = $random(seed);
    case (urand(4))
      0: x.exp = 8'hff;
      1: x = {x.sign, 8'hff, 23'h0};
      2: x = {x.sign, 31'h0};
      default: ;
    endcase
    return x;
  endfunction

  task automatic make_operands(output fp32_t a, output fp32_t b);
    int kind;
    int ea;
    kind = urand(16);
    a = $random(seed);
    b = $random(seed);
    if (kind < 5) begin
      // Normals with nearby exponents
      a.exp = 8'(1 + urand(254));
      ea = int'(a.exp) + urand(7) - 3;
      b.exp = 8'((ea < 1) ? 1 : ((ea > 254) ? 254 : ea));
      if (kind < 3) begin
        b.sign = a.sign;
      end
    end else if (kind < 8) begin
      // Opposite signs with exact cancellation for kind 5
      a.exp = 8'(1 + urand(254));
      b = a;
      b.sign = ~a.sign;
      if (kind != 5) begin
        b.frac = a.frac ^ 23'(urand(16) + 1);
      end
    end else if (kind < 10) begin
      a.exp = 8'h00;
      b.exp = 8'(urand(3));
    end else if (kind < 12) begin
      a.exp = 8'(253 + urand(2));
      b.exp = 8'(252 + urand(3));
      b.sign = a.sign;
    end else if (kind < 13) begin
      a = pick_special();
      if (urand(2) == 1) begin
        b = pick_special();
      end
    end
  endtask

  // Exact integer sum in units of 2^-149, then rounded by the mode
  function automatic expect_t reference_sum(input fp32_t a, input fp32_t b,
                                            input logic [2:0] code);
    logic [2:0]   m;
    logic [299:0] va;
    logic [299:0] vb;
    logic [299:0] mag;
    logic         sign;
    logic         g;
    logic         st;
    logic         inc;
    logic         to_inf;
    logic [24:0]  keep;
    int           p;
    int           sh;
    int           ex;
    expect_t      e;
    m = (code > 3'd4) ? 3'd0 : code;
    e = '0;
    e.a = a;
    e.b = b;
    e.mode = code;
    p = 0;
    if (((a.exp == 8'hff) && (a.frac != 0)) || ((b.exp == 8'hff) && (b.frac != 0)) ||
        ((a.exp == 8'hff) && (b.exp == 8'hff) && (a.sign != b.sign))) begin
      e.result = 32'h7fc00000;
    end else if (a.exp == 8'hff) begin
      e.result = a;
    end else if (b.exp == 8'hff) begin
      e.result = b;
    end else begin
      va = {276'd0, a.exp != 8'd0, a.frac};
      vb = {276'd0, b.exp != 8'd0, b.frac};
      va = va << ((a.exp == 8'd0) ? 0 : int'(a.exp) - 1);
      vb = vb << ((b.exp == 8'd0) ? 0 : int'(b.exp) - 1);
      if (a.sign == b.sign) begin
        mag = va + vb;
        sign = a.sign;
      end else if (va >= vb) begin
        mag = va - vb;
        sign = a.sign;
      end else begin
        mag = vb - va;
        sign = b.sign;
      end
      for (int i = 0; i < 300; i++) begin
        if (mag[i]) begin
          p = i;
        end
      end
      if (mag == '0) begin
        sign = (a.sign == b.sign) ? a.sign : (m == 3'd2);
        e.result = {sign, 31'h0};
      end else if (p <= 23) begin
        // Fits the subnormal or smallest normal range without rounding
        e.result = {sign, 7'd0, mag[23], mag[22:0]};
        e.unf = ~mag[23];
      end else begin
        sh = p - 23;
        keep = 25'(mag >> sh);
        g = mag[sh - 1];
        st = |(mag & ((300'd1 << (sh - 1)) - 300'd1));
        case (m)
          3'd1: inc = 1'b0;
          3'd2: inc = sign & (g | st);
          3'd3: inc = ~sign & (g | st);
          3'd4: inc = g;
          default: inc = g & (st | keep[0]);
        endcase
        keep = keep + 25'(inc);
        ex = sh + 1;
        if (keep[24]) begin
          keep = keep >> 1;
          ex = ex + 1;
        end
        if (ex >= 255) begin
          e.ovf = 1'b1;
          to_inf = (m == 3'd0) || (m == 3'd4) || ((m == 3'd3) && !sign) || ((m == 3'd2) && sign);
          e.result = to_inf ? {sign, 8'hff, 23'h0} : {sign, 8'hfe, 23'h7fffff};
        end else begin
          e.result = {sign, 8'(ex), keep[22:0]};
        end
      end
    end
    return e;
  endfunction

  task automatic check_result(input fp32_t got, input expect_t e);
    if (got !== e.result) begin
      $display("FAILED %0t ns: result %h expected %h for %h + %h mode %0d",
               $time, got, e.result, e.a, e.b, e.mode);
      result_errors++;
    end
  endtask

  task automatic check_flags(input logic ovf, input logic unf, input expect_t e);
    if ((ovf !== e.ovf) || (unf !== e.unf)) begin
      $display("FAILED %0t ns: overflow %b underflow %b expected %b %b for %h + %h mode %0d",
               $time, ovf, unf, e.ovf, e.unf, e.a, e.b, e.mode);
      flag_errors++;
    end
  endtask

  // Registered outputs are stable at the falling edge
  task automatic observe();
    expect_t e;
    if (out_valid === 1'b1) begin
      if (expected_q.size() == 0) begin
        $display("A result appeared at %0t ns with no operation pending", $time);
        sequence_errors++;
      end else begin
        e = expected_q.pop_front();
        if (cycles - int'(e.issue) != PIPE_DEPTH) begin
          $display("Result for %h + %h came %0d cycles after issue instead of %0d",
                   e.a, e.b, cycles - int'(e.issue), PIPE_DEPTH);
          sequence_errors++;
        end
        check_result(result, e);
        check_flags(overflow, underflow, e);
      end
    end
  endtask

  task automatic issue_op(input fp32_t a, input fp32_t b, input round_mode_t mode);
    expect_t e;
    op_a = a;
    op_b = b;
    r_mode = mode;
    in_valid = 1'b1;
    e = reference_sum(a, b, mode);
    e.issue = cycles;
    expected_q.push_back(e);
  endtask

  task automatic run_directed(input fp32_t a, input fp32_t b, input round_mode_t mode);
    @(negedge clk);
    observe();
    issue_op(a, b, mode);
  endtask

  initial begin
    seed = 32'h72e3454d;
    reset = 1'b1;
    in_valid = 1'b0;
    op_a = '0;
    op_b = '0;
    r_mode = rnd_even;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      observe();
    end
    reset = 1'b0;

    // Corner cases for specials, signed zero, overflow and subnormals
    run_directed(32'h7f800000, 32'hff800000, rnd_even);
    run_directed(32'h7fc00001, 32'h3f800000, rnd_even);
    run_directed(32'hff800000, 32'h3f800000, rnd_zero);
    run_directed(32'h3f800000, 32'hbf800000, rnd_down);
    run_directed(32'h3f800000, 32'hbf800000, rnd_even);
    run_directed(32'h7f7fffff, 32'h7f7fffff, rnd_zero);
    run_directed(32'h7f7fffff, 32'h7f7fffff, rnd_max);
    run_directed(32'hff7fffff, 32'hff7fffff, rnd_up);
    run_directed(32'hff7fffff, 32'hff7fffff, rnd_down);
    run_directed(32'h00000001, 32'h80000003, rnd_even);

    // Back to back for the first half and random gaps after
    for (int n = 0; n < NUM_OPS; n++) begin
      @(negedge clk);
      observe();
      make_operands(rand_a, rand_b);
      issue_op(rand_a, rand_b, round_mode_t'(3'(urand(8))));
      gap = (n < NUM_OPS / 2) ? 0 : urand(MAX_GAP + 1);
      repeat (gap) begin
        @(negedge clk);
        observe();
        in_valid = 1'b0;
      end
    end
    do begin
      @(negedge clk);
      observe();
      in_valid = 1'b0;
    end while (expected_q.size() != 0);
    repeat (3) begin
      @(negedge clk);
      observe();
    end

    $display("Errors: result %0d, flags %0d, sequence %0d",
             result_errors, flag_errors, sequence_errors);
    if (result_errors + flag_errors + sequence_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- tb/fp_adder_asserts.sv
`timescale 1ns/1ns

module fp_adder_asserts import fp_types_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  in_valid,
  input logic  out_valid,
  input fp32_t result,
  input logic  overflow,
  input logic  underflow
);

  // Output register is cleared by every reset edge
  property outputs_cleared;
    @(posedge clk) reset |=> (!out_valid && (result == '0) && !overflow && !underflow);
  endproperty

  // Two register stages between in_valid and out_valid
  property valid_delay;
    @(posedge clk) disable iff (reset)
      (!$past(reset) && !$past(reset, 2)) |-> (out_valid == $past(in_valid, 2));
  endproperty

  property flags_exclusive;
    @(posedge clk) disable iff (reset) !(overflow && underflow);
  endproperty

  // Infinity or largest finite value
  property overflow_exponent;
    @(posedge clk) disable iff (reset)
      overflow |-> ((result.exp == EXP_MAX) || (result.exp == EXP_MAX - 8'd1));
  endproperty

  assert property (outputs_cleared) else $error("Outputs not cleared after reset");
  assert property (valid_delay) else $error("out_valid does not follow in_valid by 2 cycles");
  assert property (flags_exclusive) else $error("overflow and underflow both set");
  assert property (overflow_exponent) else $error("Overflow result has wrong exponent");

endmodule

//--- design/fp_adder.sv
`timescale 1ns/1ns

module fp_adder import fp_types_pkg::*, fp_stage_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  input  fp32_t       op_a,
  input  fp32_t       op_b,
  input  round_mode_t r_mode,
  output logic        out_valid,
  output fp32_t       result,
  output logic        overflow,
  output logic        underflow
);

  fp_unpacked_t a_fields;
  fp_unpacked_t b_fields;
  fp_aligned_t  aligned;
  logic         aligned_valid;
  fp_sum_t      sum;
  fp_norm_t     norm;

  fp_unpack u_unpack_a (
    .operand (op_a),
    .fields  (a_fields)
  );

  fp_unpack u_unpack_b (
    .operand (op_b),
    .fields  (b_fields)
  );

  // First register stage
  fp_align u_align (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .a             (a_fields),
    .b             (b_fields),
    .r_mode        (r_mode),
    .aligned       (aligned),
    .aligned_valid (aligned_valid)
  );

  fp_mant_add u_mant_add (
    .aligned (aligned),
    .sum     (sum)
  );

  fp_normalize u_normalize (
    .sum  (sum),
    .norm (norm)
  );

  // Second register stage, valid travels straight from alignment
  fp_round u_round (
    .clk        (clk),
    .reset      (reset),
    .norm_valid (aligned_valid),
    .norm       (norm),
    .out_valid  (out_valid),
    .result     (result),
    .overflow   (overflow),
    .underflow  (underflow)
  );

endmodule

//--- design/fp_round.sv
`timescale 1ns/1ns

`include "fp_defines.svh"

module fp_round import fp_types_pkg::*, fp_stage_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     norm_valid,
  input  fp_norm_t norm,
  output logic     out_valid,
  output fp32_t    result,
  output logic     overflow,
  output logic     underflow
);

  localparam int SIG_W = `FP_MAN_W + 1;

  logic [SIG_W-1:0]   keep;
  logic               lsb;
  logic               guard;
  logic               rest;
  logic               inc;
  logic               to_inf;
  logic [SIG_W:0]     rounded;
  logic [`FP_EXP_W:0] exp_final;
  fp32_t              result_next;
  logic               overflow_next;
  logic               underflow_next;

  always_comb begin
    keep  = norm.mant[`FP_EXT_W-1:`FP_GRS_W];
    lsb   = norm.mant[`FP_GRS_W];
    guard = norm.mant[`FP_GRS_W-1];
    rest  = |norm.mant[`FP_GRS_W-2:0];

    case (norm.mode)
      rnd_zero: inc = 1'b0;
      rnd_down: inc = norm.sign & (guard | rest);
      rnd_up:   inc = ~norm.sign & (guard | rest);
      rnd_max:  inc = guard;
      default:  inc = guard & (rest | lsb);
    endcase

    // Directed modes saturate when rounding away from infinity
    case (norm.mode)
      rnd_zero: to_inf = 1'b0;
      rnd_down: to_inf = norm.sign;
      rnd_up:   to_inf = ~norm.sign;
      default:  to_inf = 1'b1;
    endcase

    rounded = {1'b0, keep} + {{SIG_W{1'b0}}, inc};

    // Mantissa carry bumps the exponent; a subnormal reaching bit 23 becomes normal
    if (rounded[SIG_W]) begin
      exp_final = {1'b0, norm.exp} + 1'b1;
    end else if ((norm.exp == '0) && rounded[SIG_W-1]) begin
      exp_final = {{`FP_EXP_W{1'b0}}, 1'b1};
    end else begin
      exp_final = {1'b0, norm.exp};
    end

    overflow_next  = 1'b0;
    underflow_next = 1'b0;
    if (norm.spc == spc_nan) begin
      result_next = FP_QNAN;
    end else if (norm.spc == spc_inf) begin
      result_next = {norm.spc_sign, EXP_MAX, {`FP_MAN_W{1'b0}}};
    end else if (exp_final >= {1'b0, EXP_MAX}) begin
      overflow_next = 1'b1;
      if (to_inf) begin
        result_next = {norm.sign, EXP_MAX, {`FP_MAN_W{1'b0}}};
      end else begin
        result_next = {norm.sign, EXP_MAX - 1'b1, {`FP_MAN_W{1'b1}}};
      end
    end else begin
      // Fraction bits are all zero after a mantissa carry
      result_next    = {norm.sign, exp_final[`FP_EXP_W-1:0], rounded[`FP_MAN_W-1:0]};
      underflow_next = ~norm.zero && (exp_final == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      result    <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      out_valid <= norm_valid;
      if (norm_valid) begin
        result    <= result_next;
        overflow  <= overflow_next;
        underflow <= underflow_next;
      end
    end
  end

endmodule

//--- design/fp_normalize.sv
`timescale 1ns/1ns

`include "fp_defines.svh"

module fp_normalize import fp_stage_pkg::*; (
  input  fp_sum_t  sum,
  output fp_norm_t norm
);

  logic [`FP_EXP_W-1:0] lz;
  logic [`FP_EXP_W-1:0] shift;
  logic [`FP_EXP_W-1:0] exp_room;

  // Zeros above the hidden bit position
  function automatic logic [`FP_EXP_W-1:0] count_lz(input logic [`FP_EXT_W-1:0] value);
    logic [`FP_EXP_W-1:0] count;
    logic                 found;
    count = '0;
    found = 1'b0;
    for (int i = `FP_EXT_W - 1; i >= 0; i--) begin
      if (value[i]) begin
        found = 1'b1;
      end else if (!found) begin
        count = count + 1'b1;
      end
    end
    return count;
  endfunction

  always_comb begin
    lz       = count_lz(sum.mag[`FP_EXT_W-1:0]);
    // Left shifts stop at effective exponent 1
    exp_room = sum.exp - 1'b1;
    shift    = '0;

    norm.sign     = sum.sign;
    norm.zero     = sum.exact_zero;
    norm.mode     = sum.mode;
    norm.spc      = sum.spc;
    norm.spc_sign = sum.spc_sign;

    if (sum.exact_zero) begin
      norm.exp  = '0;
      norm.mant = '0;
    end else if (sum.mag[`FP_EXT_W]) begin
      // Carry out, one place right keeping the lost bit as sticky
      norm.exp  = sum.exp + 1'b1;
      norm.mant = {sum.mag[`FP_EXT_W:2], |sum.mag[1:0]};
    end else begin
      if (lz <= exp_room) begin
        shift    = lz;
        norm.exp = sum.exp - lz;
      end else begin
        // Limit reached, result stays subnormal
        shift    = exp_room;
        norm.exp = '0;
      end
      norm.mant = sum.mag[`FP_EXT_W-1:0] << shift;
    end
  end

endmodule

//--- design/fp_mant_add.sv
`timescale 1ns/1ns

`include "fp_defines.svh"

module fp_mant_add import fp_stage_pkg::*; (
  input  fp_aligned_t aligned,
  output fp_sum_t     sum
);

  logic [`FP_EXT_W:0] large_ext;
  logic [`FP_EXT_W:0] small_ext;
  logic [`FP_EXT_W:0] mag;
  logic               mag_zero;

  always_comb begin
    // One spare bit on top holds the carry of an addition
    large_ext = {1'b0, aligned.mant_large};
    small_ext = {1'b0, aligned.mant_small};

    // Larger operand comes first, so the difference never goes negative
    if (aligned.eff_sub) begin
      mag = large_ext - small_ext;
    end else begin
      mag = large_ext + small_ext;
    end

    mag_zero = (mag == '0);

    sum.mag        = mag;
    sum.exp        = aligned.exp;
    sum.exact_zero = mag_zero;

    // Result follows the larger operand unless everything cancelled
    if (mag_zero) begin
      sum.sign = aligned.zero_sign;
    end else begin
      sum.sign = aligned.sign;
    end

    sum.mode     = aligned.mode;
    sum.spc      = aligned.spc;
    sum.spc_sign = aligned.spc_sign;
  end

endmodule

//--- design/fp_align.sv
`timescale 1ns/1ns

`include "fp_defines.svh"

module fp_align import fp_types_pkg::*, fp_stage_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         in_valid,
  input  fp_unpacked_t a,
  input  fp_unpacked_t b,
  input  round_mode_t  r_mode,
  output fp_aligned_t  aligned,
  output logic         aligned_valid
);

  fp_unpacked_t             op_large;
  fp_unpacked_t             op_small;
  logic                     a_larger;
  logic [`FP_EXP_W-1:0]     exp_diff;
  logic [`FP_EXT_W-1:0]     small_ext;
  logic [2*`FP_EXT_W-1:0]   shift_buf;
  fp_aligned_t              aligned_next;

  always_comb begin
    // Exponent and mantissa together order the magnitudes
    a_larger = ({a.exp, a.mant} >= {b.exp, b.mant});
    op_large = a_larger ? a : b;
    op_small = a_larger ? b : a;
    exp_diff = op_large.exp - op_small.exp;

    // Lower half of the buffer catches everything shifted out
    small_ext = {op_small.mant, {`FP_GRS_W{1'b0}}};
    shift_buf = {small_ext, {`FP_EXT_W{1'b0}}} >> exp_diff;

    aligned_next.sign       = op_large.sign;
    aligned_next.eff_sub    = a.sign ^ b.sign;
    aligned_next.exp        = op_large.exp;
    aligned_next.mant_large = {op_large.mant, {`FP_GRS_W{1'b0}}};
    if (exp_diff >= `FP_EXT_W) begin
      aligned_next.mant_small = {{(`FP_EXT_W-1){1'b0}}, |op_small.mant};
    end else begin
      aligned_next.mant_small = {shift_buf[2*`FP_EXT_W-1:`FP_EXT_W+1],
                                 |shift_buf[`FP_EXT_W:0]};
    end

    // Equal signs only cancel when both are zero, opposite signs follow the mode
    aligned_next.zero_sign = aligned_next.eff_sub ? (r_mode == rnd_down) : a.sign;
    aligned_next.mode      = r_mode;

    aligned_next.spc      = spc_none;
    aligned_next.spc_sign = 1'b0;
    if (a.is_nan || b.is_nan || (a.is_inf && b.is_inf && (a.sign != b.sign))) begin
      aligned_next.spc = spc_nan;
    end else if (a.is_inf || b.is_inf) begin
      aligned_next.spc      = spc_inf;
      aligned_next.spc_sign = a.is_inf ? a.sign : b.sign;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      aligned_valid <= 1'b0;
    end else begin
      aligned_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      aligned <= aligned_next;
    end
  end

endmodule

//--- design/fp_unpack.sv
`timescale 1ns/1ns

`include "fp_defines.svh"

module fp_unpack import fp_types_pkg::*; (
  input  fp32_t        operand,
  output fp_unpacked_t fields
);

  logic exp_zero;
  logic exp_ones;
  logic frac_zero;

  always_comb begin
    exp_zero  = (operand.exp == '0);
    exp_ones  = (operand.exp == EXP_MAX);
    frac_zero = (operand.frac == '0);

    fields.sign = operand.sign;

    // Subnormals share the weight of exponent 1 with the smallest normals
    if (exp_zero) begin
      fields.exp = {{(`FP_EXP_W-1){1'b0}}, 1'b1};
    end else begin
      fields.exp = operand.exp;
    end

    // Hidden bit only for normal numbers
    fields.mant = {~exp_zero, operand.frac};

    fields.is_zero      = exp_zero & frac_zero;
    fields.is_subnormal = exp_zero & ~frac_zero;
    fields.is_inf       = exp_ones & frac_zero;
    fields.is_nan       = exp_ones & ~frac_zero;
  end

endmodule

//--- design/fp_stage_pkg.sv
package fp_stage_pkg;

  `include "fp_defines.svh"

  import fp_types_pkg::*;

  // Registered output of the alignment stage
  typedef struct packed {
    logic                 sign;       // Sign of the larger operand
    logic                 eff_sub;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_EXT_W-1:0] mant_large;
    logic [`FP_EXT_W-1:0] mant_small; // Already shifted, sticky in bit 0
    logic                 zero_sign;  // Sign an exact zero result takes
    round_mode_t          mode;
    special_t             spc;
    logic                 spc_sign;
  } fp_aligned_t;

  // Raw magnitude with one carry bit above the extended width
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_EXT_W:0]   mag;
    logic                 exact_zero;
    round_mode_t          mode;
    special_t             spc;
    logic                 spc_sign;
  } fp_sum_t;

  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;   // Field value, 0 for subnormal results
    logic [`FP_EXT_W-1:0] mant;
    logic                 zero;
    round_mode_t          mode;
    special_t             spc;
    logic                 spc_sign;
  } fp_norm_t;

endpackage

//--- design/fp_types_pkg.sv
package fp_types_pkg;

  `include "fp_defines.svh"

  // Reserved exponent field for infinity and NaN
  localparam logic [`FP_EXP_W-1:0] EXP_MAX = 2 * `FP_BIAS + 1;

  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;
    logic [`FP_MAN_W-1:0] frac;
  } fp32_t;

  // Canonical quiet NaN returned for every invalid case
  localparam fp32_t FP_QNAN = 32'h7fc00000;

  // Operand after classification
  typedef struct packed {
    logic                 sign;
    logic [`FP_EXP_W-1:0] exp;   // Subnormals carry exponent 1 here
    logic [`FP_MAN_W:0]   mant;  // Hidden bit on top
    logic                 is_zero;
    logic                 is_subnormal;
    logic                 is_inf;
    logic                 is_nan;
  } fp_unpacked_t;

  // Codes above rnd_max fall back to nearest even
  typedef enum logic [2:0] {
    rnd_even = 3'b000,
    rnd_zero = 3'b001,
    rnd_down = 3'b010,
    rnd_up   = 3'b011,
    rnd_max  = 3'b100
  } round_mode_t;

  typedef enum logic [1:0] {
    spc_none = 2'b00,
    spc_nan  = 2'b01,
    spc_inf  = 2'b10
  } special_t;

endpackage

//--- include/fp_defines.svh
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// binary32 field widths
`define FP_EXP_W 8
`define FP_MAN_W 23

// Exponent bias of the format
`define FP_BIAS 127

// Guard, round and sticky below the stored fraction
`define FP_GRS_W 3

// Hidden bit + fraction + guard/round/sticky
`define FP_EXT_W 27

`endif
